// File: project.f
common/voice_pkg.sv
design/midi_parser.sv
note_stack/note_stack.sv
design/voice_arbiter.sv
design/voice_table.sv
design/voice_scanner.sv
design/midi_voice_top.sv
testbench/midi_voice_assertions.sv
testbench/tb_midi_voice.sv

// File: Bender.yml
package:
  name: midi_voice

sources:
  # shared package first
  - common/voice_pkg.sv
  - design/midi_parser.sv
  - note_stack/note_stack.sv
  - design/voice_arbiter.sv
  - design/voice_table.sv
  - design/voice_scanner.sv
  - design/midi_voice_top.sv
  - target: simulation
    files:
      - testbench/midi_voice_assertions.sv
      - testbench/tb_midi_voice.sv

// File: testbench/tb_midi_voice.sv
`timescale 1ns/100ps

module tb_midi_voice;

    localparam int num_directed = 18;
    localparam int num_random = 300;
    localparam int msg_budget = 200;
    // one extra slot for the closing scan
    localparam int watchdog_cycles = (num_directed + num_random + 1) * msg_budget;

    logic                     reg_clk = 1'b0;
    logic                     reset = 1'b1;
    logic                     midi_req = 1'b0;
    logic [7:0]               midi_byte = 8'h00;
    logic                     midi_ack;
    voice_pkg::voice_mask_t   key_on;
    voice_pkg::voice_count_t  active_count;
    voice_pkg::voice_report_t report;
    logic                     report_valid;

    // reference model
    voice_pkg::voice_mask_t  m_key_on = '0;
    logic [6:0]              m_keys [voice_pkg::voices];
    int unsigned             m_age [voice_pkg::voices];
    voice_pkg::voice_entry_t m_entry [voice_pkg::voices];
    int unsigned             age_stamp = 0;

    logic [31:0]           seed = 32'h13228303;
    logic [3:0]            running = 4'h0;
    logic                  busy = 1'b0;
    voice_pkg::voice_idx_t next_voice = '0;
    int                    report_count = 0;
    string                 test_name = "reset";

    midi_voice_top midi_voice_top_inst (
        .reg_clk      (reg_clk),
        .reset        (reset),
        .midi_req     (midi_req),
        .midi_byte    (midi_byte),
        .midi_ack     (midi_ack),
        .key_on       (key_on),
        .active_count (active_count),
        .report       (report),
        .report_valid (report_valid)
    );

    always #2 reg_clk = ~reg_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    task automatic check_mask(input string name, input voice_pkg::voice_mask_t exp,
                              input voice_pkg::voice_mask_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "key mask mismatch");
        end
    endtask

    task automatic check_count(input string name, input voice_pkg::voice_count_t exp,
                               input voice_pkg::voice_count_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "voice count mismatch");
        end
    endtask

    task automatic check_report(input string name, input voice_pkg::voice_report_t exp,
                                input voice_pkg::voice_report_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "voice report mismatch");
        end
    endtask

    // one message worth of allocation rules
    function automatic void apply_msg(input logic [3:0] hi, input logic [6:0] d1,
                                      input logic [6:0] d2);
        int v;
        v = -1;
        if (hi == 4'h9 && d2 != 7'd0) begin
            for (int i = 0; i < voice_pkg::voices; i++) begin
                if (!m_key_on[i] && v < 0) begin
                    v = i;
                end
            end
            // pool full, take the oldest note
            if (v < 0) begin
                v = 0;
                for (int i = 1; i < voice_pkg::voices; i++) begin
                    if (m_age[i] < m_age[v]) begin
                        v = i;
                    end
                end
            end
            age_stamp++;
            m_age[v] = age_stamp;
            m_keys[v] = d1;
            m_key_on[v] = 1'b1;
            m_entry[v] = '{gate: 1'b1, key: d1, velocity: {1'b0, d2}};
        end else if (hi == 4'h8 || hi == 4'h9) begin
            for (int i = 0; i < voice_pkg::voices; i++) begin
                if (m_key_on[i] && m_keys[i] == d1) begin
                    m_key_on[i] = 1'b0;
                    m_entry[i] = '{gate: 1'b0, key: m_keys[i], velocity: {1'b0, d2}};
                end
            end
        end else if (hi == 4'hb && d1 == voice_pkg::cc_all_notes_off) begin
            m_key_on = '0;
            for (int i = 0; i < voice_pkg::voices; i++) begin
                m_entry[i] = '{gate: 1'b0, key: m_keys[i], velocity: 8'd0};
            end
        end
    endfunction

    // starts and ends at 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] b);
        midi_byte = b;
        midi_req = 1'b1;
        do @(negedge reg_clk); while (!midi_ack);
        @(posedge reg_clk);
        #1;
        midi_req = 1'b0;
        do @(negedge reg_clk); while (midi_ack);
        @(posedge reg_clk);
        #1;
    endtask

    task automatic maybe_realtime();
        logic [31:0] r;
        r = next_rand();
        if (r[2:0] == 3'd0) begin
            send_byte(8'hf8 | {5'd0, r[10:8]});
        end
    endtask

    task automatic send_msg(input logic [3:0] hi, input logic [6:0] d1, input logic [6:0] d2);
        logic [31:0] r;
        r = next_rand();
        // status byte may be left out under running status
        if (hi != running || r[4]) begin
            send_byte({hi, r[3:0]});
            running = hi;
        end
        maybe_realtime();
        send_byte({1'b0, d1});
        maybe_realtime();
        // the closing data byte starts the table writes
        busy = 1'b1;
        send_byte({1'b0, d2});
        apply_msg(hi, d1, d2);
        busy = 1'b0;
        check_mask({test_name, " key_on"}, m_key_on, key_on);
        check_count({test_name, " active_count"},
                    voice_pkg::voice_count_t'($countones(m_key_on)), active_count);
    endtask

    // system common byte, drops running status
    task automatic send_common();
        logic [31:0] r;
        r = next_rand();
        send_byte({5'b11110, r[2:0]});
        running = 4'h0;
        check_mask({test_name, " key_on"}, m_key_on, key_on);
    endtask

    always @(negedge reg_clk) begin
        voice_pkg::voice_report_t exp;
        if (!reset && report_valid) begin
            exp = '{voice: next_voice, entry: m_entry[next_voice]};
            // table writes in flight while busy
            if (!busy) begin
                check_report({test_name, " report"}, exp, report);
            end
            next_voice = next_voice + 3'd1;
            report_count++;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge reg_clk);
        $display("timeout: the DUT did not finish the test sequence in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // a bound assertion failure ends the run at once
    initial begin
        wait (midi_voice_top_inst.midi_voice_assertions_inst.fail_count != 0);
        $display("a handshake or voice count assertion failed");
        $display("ERRORS FOUND");
        $fatal(1, "assertion failure");
    end

    initial begin
        logic [31:0] r;
        logic [6:0]  key;
        logic [6:0]  vel;
        int          target;
        for (int i = 0; i < voice_pkg::voices; i++) begin
            m_keys[i] = 7'd0;
            m_age[i] = 0;
            m_entry[i] = '0;
        end
        repeat (5) @(posedge reg_clk);
        #1;
        reset = 1'b0;

        test_name = "allocation";
        for (int i = 0; i < voice_pkg::voices; i++) begin
            send_msg(4'h9, 7'(60 + i), 7'(64 + i));
        end
        test_name = "stealing";
        send_msg(4'h9, 7'd72, 7'd100);
        send_msg(4'h9, 7'd73, 7'd101);
        test_name = "release";
        send_msg(4'h8, 7'd62, 7'd40);
        send_msg(4'h9, 7'd63, 7'd0);
        test_name = "duplicate key";
        send_msg(4'h9, 7'd50, 7'd10);
        send_msg(4'h9, 7'd50, 7'd20);
        send_msg(4'h8, 7'd50, 7'd5);
        test_name = "other cc";
        send_msg(4'hb, 7'd7, 7'd100);
        test_name = "all notes off";
        send_msg(4'hb, voice_pkg::cc_all_notes_off, 7'd0);
        send_common();

        test_name = "random";
        for (int n = 0; n < num_random; n++) begin
            r = next_rand();
            // small key range so keys repeat
            key = 7'd60 + 7'(r[7:4] % 4'd12);
            vel = 7'(r[14:8] % 7'd127) + 7'd1;
            case (r[19:16])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: send_msg(4'h9, key, vel);
                4'd7, 4'd8, 4'd9, 4'd10: send_msg(4'h8, key, r[26:20]);
                4'd11, 4'd12: send_msg(4'h9, key, 7'd0);
                4'd13: send_msg(4'hb, voice_pkg::cc_all_notes_off, r[26:20]);
                4'd14: send_msg(4'hb, 7'(r[26:20] % 7'd120), vel);
                default: send_common();
            endcase
        end

        // two full scans after the last message
        test_name = "final scan";
        target = report_count + 2 * voice_pkg::voices;
        while (report_count < target) @(posedge reg_clk);

        if (midi_voice_top_inst.midi_voice_assertions_inst.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("a handshake or voice count assertion failed");
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: testbench/midi_voice_assertions.sv
`timescale 1ns/100ps

module midi_voice_assertions (
    input logic                    reg_clk,
    input logic                    reset,
    input logic                    midi_req,
    input logic                    midi_ack,
    input logic                    ev_req,
    input logic                    ev_ack,
    input voice_pkg::voice_mask_t  key_on,
    input voice_pkg::voice_count_t active_count
);

    // number of failed assertions so far
    int unsigned fail_count = 0;

    // four-phase rules on the byte input
    midi_ack_needs_req: assert property (@(posedge reg_clk) disable iff (reset)
        $rose(midi_ack) |-> midi_req)
        else begin
            $error("midi_ack rose without midi_req");
            fail_count++;
        end

    midi_req_holds: assert property (@(posedge reg_clk) disable iff (reset)
        $fell(midi_req) |-> midi_ack)
        else begin
            $error("midi_req dropped before midi_ack");
            fail_count++;
        end

    // same rules on the event path
    ev_ack_needs_req: assert property (@(posedge reg_clk) disable iff (reset)
        $rose(ev_ack) |-> ev_req)
        else begin
            $error("ev_ack rose without ev_req");
            fail_count++;
        end

    ev_req_holds: assert property (@(posedge reg_clk) disable iff (reset)
        $fell(ev_req) |-> ev_ack)
        else begin
            $error("ev_req dropped before ev_ack");
            fail_count++;
        end

    count_matches_mask: assert property (@(posedge reg_clk) disable iff (reset)
        active_count == $countones(key_on))
        else begin
            $error("active_count differs from the number of held voices");
            fail_count++;
        end

endmodule

bind midi_voice_top midi_voice_assertions midi_voice_assertions_inst (
    .reg_clk      (reg_clk),
    .reset        (reset),
    .midi_req     (midi_req),
    .midi_ack     (midi_ack),
    .ev_req       (ev_req),
    .ev_ack       (ev_ack),
    .key_on       (key_on),
    .active_count (active_count)
);

// File: design/midi_voice_top.sv
`timescale 1ns/100ps

module midi_voice_top (
    input  logic                     reg_clk,
    input  logic                     reset,
    input  logic                     midi_req,
    input  logic [7:0]               midi_byte,
    output logic                     midi_ack,
    output voice_pkg::voice_mask_t   key_on,
    output voice_pkg::voice_count_t  active_count,
    output voice_pkg::voice_report_t report,
    output logic                     report_valid
);

    logic                    ev_req;
    logic                    ev_ack;
    voice_pkg::midi_event_t  ev;
    logic                    ns_req;
    logic                    ns_ack;
    voice_pkg::table_req_t   ns_tbl;
    logic                    sc_req;
    logic                    sc_ack;
    voice_pkg::table_req_t   sc_tbl;
    voice_pkg::voice_entry_t rd_data;
    logic                    mem_req;
    logic                    mem_ack;
    voice_pkg::table_req_t   mem_tbl;
    voice_pkg::voice_entry_t mem_rd;

    midi_parser midi_parser_inst (
        .reg_clk   (reg_clk),
        .reset     (reset),
        .midi_req  (midi_req),
        .midi_byte (midi_byte),
        .midi_ack  (midi_ack),
        .ev_req    (ev_req),
        .ev        (ev),
        .ev_ack    (ev_ack)
    );

    note_stack note_stack_inst (
        .reg_clk      (reg_clk),
        .reset        (reset),
        .ev_req       (ev_req),
        .ev           (ev),
        .ev_ack       (ev_ack),
        .tbl_req      (ns_req),
        .tbl          (ns_tbl),
        .tbl_ack      (ns_ack),
        .key_on       (key_on),
        .active_count (active_count)
    );

    // scanner and note stack share one table port
    voice_arbiter voice_arbiter_inst (
        .reg_clk (reg_clk),
        .reset   (reset),
        .ns_req  (ns_req),
        .ns_tbl  (ns_tbl),
        .ns_ack  (ns_ack),
        .sc_req  (sc_req),
        .sc_tbl  (sc_tbl),
        .sc_ack  (sc_ack),
        .rd_data (rd_data),
        .mem_req (mem_req),
        .mem_tbl (mem_tbl),
        .mem_ack (mem_ack),
        .mem_rd  (mem_rd)
    );

    voice_table voice_table_inst (
        .reg_clk (reg_clk),
        .reset   (reset),
        .req     (mem_req),
        .tbl     (mem_tbl),
        .ack     (mem_ack),
        .rd      (mem_rd)
    );

    voice_scanner voice_scanner_inst (
        .reg_clk      (reg_clk),
        .reset        (reset),
        .tbl_req      (sc_req),
        .tbl          (sc_tbl),
        .tbl_ack      (sc_ack),
        .rd           (rd_data),
        .report       (report),
        .report_valid (report_valid)
    );

endmodule

// File: design/voice_scanner.sv
`timescale 1ns/100ps

module voice_scanner (
    input  logic                     reg_clk,
    input  logic                     reset,
    output logic                     tbl_req,
    output voice_pkg::table_req_t    tbl,
    input  logic                     tbl_ack,
    input  voice_pkg::voice_entry_t  rd,
    output voice_pkg::voice_report_t report,
    output logic                     report_valid
);

    typedef enum logic {
        st_read,
        st_release
    } state_t;

    state_t state;
    voice_pkg::voice_idx_t voice_q;

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            state <= st_read;
            voice_q <= '0;
            report_valid <= 1'b0;
        end else begin
            report_valid <= 1'b0;
            case (state)
                st_read: begin
                    if (tbl_ack) begin
                        report_valid <= 1'b1;
                        state <= st_release;
                    end
                end
                default: begin
                    // wraps from 7 back to 0
                    if (!tbl_ack) begin
                        voice_q <= voice_q + 3'd1;
                        state <= st_read;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge reg_clk) begin
        if (state == st_read && tbl_ack) begin
            report <= '{voice: voice_q, entry: rd};
        end
    end

    assign tbl_req = (state == st_read);
    assign tbl.write = 1'b0;
    assign tbl.addr = voice_q;
    assign tbl.data = '0;

endmodule

// File: design/voice_table.sv
`timescale 1ns/100ps

module voice_table (
    input  logic                    reg_clk,
    input  logic                    reset,
    input  logic                    req,
    input  voice_pkg::table_req_t   tbl,
    output logic                    ack,
    output voice_pkg::voice_entry_t rd
);

    voice_pkg::voice_entry_t entries [voice_pkg::voices];

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            ack <= 1'b0;
            for (int i = 0; i < voice_pkg::voices; i++) begin
                entries[i] <= '0;
            end
        end else begin
            // ack follows req by one cycle in both directions
            ack <= req;
            if (req && !ack) begin
                if (tbl.write) begin
                    entries[tbl.addr] <= tbl.data;
                end
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge reg_clk) begin
        if (req && !ack) begin
            rd <= entries[tbl.addr];
        end
    end

endmodule

// File: design/voice_arbiter.sv
`timescale 1ns/100ps

module voice_arbiter (
    input  logic                    reg_clk,
    input  logic                    reset,
    input  logic                    ns_req,
    input  voice_pkg::table_req_t   ns_tbl,
    output logic                    ns_ack,
    input  logic                    sc_req,
    input  voice_pkg::table_req_t   sc_tbl,
    output logic                    sc_ack,
    output voice_pkg::voice_entry_t rd_data,
    output logic                    mem_req,
    output voice_pkg::table_req_t   mem_tbl,
    input  logic                    mem_ack,
    input  voice_pkg::voice_entry_t mem_rd
);

    typedef enum logic [1:0] {
        gnt_none,
        gnt_ns,
        gnt_sc
    } grant_t;

    grant_t grant;

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            grant <= gnt_none;
        end else begin
            case (grant)
                gnt_none: begin
                    // note stack wins a tie
                    if (ns_req) begin
                        grant <= gnt_ns;
                    end else if (sc_req) begin
                        grant <= gnt_sc;
                    end
                end
                gnt_ns: begin
                    if (!ns_req && !mem_ack) begin
                        grant <= gnt_none;
                    end
                end
                default: begin
                    if (!sc_req && !mem_ack) begin
                        grant <= gnt_none;
                    end
                end
            endcase
        end
    end

    always_comb begin
        mem_req = 1'b0;
        if (grant == gnt_ns) begin
            mem_req = ns_req;
        end else if (grant == gnt_sc) begin
            mem_req = sc_req;
        end
        mem_tbl = (grant == gnt_sc) ? sc_tbl : ns_tbl;
    end

    assign ns_ack = (grant == gnt_ns) && mem_ack;
    assign sc_ack = (grant == gnt_sc) && mem_ack;
    // both clients share the read bus, only the granted one looks at it
    assign rd_data = mem_rd;

endmodule

// File: note_stack/note_stack.sv
`timescale 1ns/100ps

module note_stack (
    input  logic                     reg_clk,
    input  logic                     reset,
    input  logic                     ev_req,
    input  voice_pkg::midi_event_t   ev,
    output logic                     ev_ack,
    output logic                     tbl_req,
    output voice_pkg::table_req_t    tbl,
    input  logic                     tbl_ack,
    output voice_pkg::voice_mask_t   key_on,
    output voice_pkg::voice_count_t  active_count
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_wrel,
        st_done
    } state_t;

    state_t state;
    logic [6:0] keys [voice_pkg::voices];
    // age list, order[0] holds the oldest note-on
    voice_pkg::voice_idx_t order [voice_pkg::voices];
    voice_pkg::voice_mask_t pending;
    logic       gate_q;
    logic [7:0] vel_q;

    voice_pkg::voice_mask_t free_mask;
    voice_pkg::voice_mask_t match_mask;
    voice_pkg::voice_idx_t  alloc_voice;
    voice_pkg::voice_idx_t  alloc_pos;
    voice_pkg::voice_idx_t  wr_idx;

    function automatic voice_pkg::voice_idx_t lowest_bit(input voice_pkg::voice_mask_t m);
        voice_pkg::voice_idx_t idx;
        idx = '0;
        for (int i = voice_pkg::voices - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = voice_pkg::voice_idx_t'(i);
            end
        end
        return idx;
    endfunction

    function automatic voice_pkg::voice_count_t popcount(input voice_pkg::voice_mask_t m);
        voice_pkg::voice_count_t n;
        n = '0;
        for (int i = 0; i < voice_pkg::voices; i++) begin
            n = n + voice_pkg::voice_count_t'(m[i]);
        end
        return n;
    endfunction

    always_comb begin
        free_mask = ~key_on;
        // steal the oldest voice when the pool is full
        alloc_voice = (free_mask != '0) ? lowest_bit(free_mask) : order[0];
        alloc_pos = '0;
        for (int i = 0; i < voice_pkg::voices; i++) begin
            match_mask[i] = key_on[i] && (keys[i] == ev.key);
            if (order[i] == alloc_voice) begin
                alloc_pos = voice_pkg::voice_idx_t'(i);
            end
        end
        wr_idx = lowest_bit(pending);
    end

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            state <= st_idle;
            key_on <= '0;
            active_count <= '0;
            pending <= '0;
            for (int i = 0; i < voice_pkg::voices; i++) begin
                keys[i] <= 7'd0;
                order[i] <= voice_pkg::voice_idx_t'(i);
            end
        end else begin
            case (state)
                st_idle: begin
                    if (ev_req) begin
                        case (ev.kind)
                            voice_pkg::note_on: begin
                                keys[alloc_voice] <= ev.key;
                                key_on[alloc_voice] <= 1'b1;
                                active_count <= popcount(key_on |
                                    voice_pkg::voice_mask_t'(1 << alloc_voice));
                                // move the voice to the young end
                                for (int i = 0; i < voice_pkg::voices - 1; i++) begin
                                    if (i >= alloc_pos) begin
                                        order[i] <= order[i+1];
                                    end
                                end
                                order[voice_pkg::voices-1] <= alloc_voice;
                                pending <= voice_pkg::voice_mask_t'(1 << alloc_voice);
                                gate_q <= 1'b1;
                                vel_q <= {1'b0, ev.velocity};
                                state <= st_write;
                            end
                            voice_pkg::note_off: begin
                                key_on <= key_on & ~match_mask;
                                active_count <= popcount(key_on & ~match_mask);
                                pending <= match_mask;
                                gate_q <= 1'b0;
                                vel_q <= {1'b0, ev.velocity};
                                state <= (match_mask != '0) ? st_write : st_done;
                            end
                            default: begin
                                key_on <= '0;
                                active_count <= '0;
                                pending <= '1;
                                gate_q <= 1'b0;
                                vel_q <= 8'd0;
                                state <= st_write;
                            end
                        endcase
                    end
                end
                st_write: begin
                    if (tbl_ack) begin
                        pending[wr_idx] <= 1'b0;
                        state <= st_wrel;
                    end
                end
                st_wrel: begin
                    if (!tbl_ack) begin
                        state <= (pending != '0) ? st_write : st_done;
                    end
                end
                default: begin
                    if (!ev_req) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    assign tbl_req = (state == st_write);
    assign tbl.write = 1'b1;
    assign tbl.addr = wr_idx;
    assign tbl.data = '{gate: gate_q, key: keys[wr_idx], velocity: vel_q};
    assign ev_ack = (state == st_done);

endmodule

// File: design/midi_parser.sv
`timescale 1ns/100ps

module midi_parser (
    input  logic                    reg_clk,
    input  logic                    reset,
    input  logic                    midi_req,
    input  logic [7:0]              midi_byte,
    output logic                    midi_ack,
    output logic                    ev_req,
    output voice_pkg::midi_event_t  ev,
    input  logic                    ev_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_ev_req,
        st_ev_rel,
        st_ack
    } state_t;

    state_t state;
    // high nibble of the running status, 0 when there is none
    logic [3:0] status_q;
    logic [6:0] first_q;
    logic       have_first;
    voice_pkg::midi_event_t new_ev;
    logic       emit;

    always_comb begin
        new_ev.key = first_q;
        new_ev.velocity = midi_byte[6:0];
        case (status_q)
            4'h8: new_ev.kind = voice_pkg::note_off;
            4'h9: new_ev.kind = (midi_byte[6:0] == 7'd0) ? voice_pkg::note_off
                                                         : voice_pkg::note_on;
            default: new_ev.kind = voice_pkg::all_off;
        endcase
        // other controllers are absorbed here
        emit = (status_q == 4'h8) || (status_q == 4'h9) ||
               (status_q == 4'hb && first_q == voice_pkg::cc_all_notes_off);
    end

    always_ff @(posedge reg_clk) begin
        if (reset) begin
            state <= st_idle;
            status_q <= 4'h0;
            have_first <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (midi_req) begin
                        state <= st_ack;
                        if (midi_byte[7]) begin
                            // real-time bytes leave running status alone
                            if (midi_byte < 8'hf8) begin
                                status_q <= (midi_byte < 8'hf0) ? midi_byte[7:4] : 4'h0;
                                have_first <= 1'b0;
                            end
                        end else if (status_q == 4'hc || status_q == 4'hd) begin
                            // single data byte messages, nothing to do
                            have_first <= 1'b0;
                        end else if (status_q != 4'h0) begin
                            if (!have_first) begin
                                first_q <= midi_byte[6:0];
                                have_first <= 1'b1;
                            end else begin
                                have_first <= 1'b0;
                                ev <= new_ev;
                                if (emit) begin
                                    state <= st_ev_req;
                                end
                            end
                        end
                    end
                end
                st_ev_req: begin
                    if (ev_ack) begin
                        state <= st_ev_rel;
                    end
                end
                st_ev_rel: begin
                    // byte is done once the note stack has let go
                    if (!ev_ack) begin
                        state <= st_ack;
                    end
                end
                default: begin
                    if (!midi_req) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    assign ev_req = (state == st_ev_req);
    assign midi_ack = (state == st_ack);

endmodule

// File: common/voice_pkg.sv
package voice_pkg;

    // voice pool size
    localparam int voices = 8;

    // controller number for all notes off
    localparam logic [6:0] cc_all_notes_off = 7'h7b;

    typedef logic [2:0] voice_idx_t;
    typedef logic [voices-1:0] voice_mask_t;
    typedef logic [3:0] voice_count_t;

    // classified events from the parser
    typedef enum logic [1:0] {
        note_on  = 2'd0,
        note_off = 2'd1,
        all_off  = 2'd2
    } event_kind_t;

    typedef struct packed {
        event_kind_t kind;
        logic [6:0]  key;
        logic [6:0]  velocity;
    } midi_event_t;

    // one voice table entry
    // velocity is the note-on value while gated, the release value after
    typedef struct packed {
        logic       gate;
        logic [6:0] key;
        logic [7:0] velocity;
    } voice_entry_t;

    // table access, read when write is clear
    typedef struct packed {
        logic         write;
        voice_idx_t   addr;
        voice_entry_t data;
    } table_req_t;

    // streamed to the synthesis engine
    typedef struct packed {
        voice_idx_t   voice;
        voice_entry_t entry;
    } voice_report_t;

endpackage
